//--- build.f
div_pkg.sv
div_issue.sv
div_core.sv
div_writeback.sv
div_unit.sv
div_unit_sva.sv
tb_div_unit.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_div_unit
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "Test failed"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then echo "Run ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_div_unit.sv
module tb_div_unit;
    import div_pkg::*;

    localparam int XLEN           = XLEN_DEFAULT;
    localparam int TIMEOUT_CYCLES = 200;
    localparam int RANDOM_COUNT   = 200;
    localparam int QUIET_CYCLES   = XLEN + 8; // Window where nothing may come out

    logic                  clk;
    logic                  rst;
    logic                  flush;
    logic                  req_valid;
    logic [DIV_OP_W-1:0]   req_op;
    logic [XLEN-1:0]       req_rs1;
    logic [XLEN-1:0]       req_rs2;
    logic [REG_ADDR_W-1:0] req_rd;
    logic                  busy;
    logic                  result_valid;
    logic [REG_ADDR_W-1:0] result_rd;
    logic [XLEN-1:0]       result_data;

    div_unit #(.XLEN(XLEN)) dut0 (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .req_valid(req_valid),
        .req_op(req_op),
        .req_rs1(req_rs1),
        .req_rs2(req_rs2),
        .req_rd(req_rd),
        .busy(busy),
        .result_valid(result_valid),
        .result_rd(result_rd),
        .result_data(result_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // RISC-V M-extension rules with truncating division
    function automatic logic [XLEN-1:0] expected_result(
        input logic [DIV_OP_W-1:0] op,
        input logic [XLEN-1:0]     a,
        input logic [XLEN-1:0]     b
    );
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic                   overflow;
        sa = a;
        sb = b;
        overflow = (a == {1'b1, {(XLEN - 1){1'b0}}}) && (b == '1);
        case (op)
            DIV_OP_DIVU: return (b == '0) ? '1 : a / b;
            DIV_OP_REMU: return (b == '0) ? a : a % b;
            DIV_OP_DIV: begin
                if (b == '0) return '1;
                if (overflow) return a; // Most negative value comes back
                return sa / sb;
            end
            default: begin
                if (b == '0) return a;
                if (overflow) return '0;
                return sa % sb; // Sign follows the dividend
            end
        endcase
    endfunction

    task automatic check_value(input string what, input logic [XLEN-1:0] actual,
                               input logic [XLEN-1:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t: %s, got %h, expected %h", $time, what, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s at time %0t", what, $time);
        $display("SIMULATION FAILED");
        $fatal(1, "wait limit reached");
    endtask

    // All tasks below start and end just after a falling edge
    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (busy && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) report_timeout("busy to fall");
    endtask

    task automatic send_request(input logic [DIV_OP_W-1:0] op, input logic [XLEN-1:0] a,
                                input logic [XLEN-1:0] b, input logic [REG_ADDR_W-1:0] rd);
        req_op    = op;
        req_rs1   = a;
        req_rs2   = b;
        req_rd    = rd;
        req_valid = 1'b1;
    endtask

    task automatic run_division(input logic [DIV_OP_W-1:0] op, input logic [XLEN-1:0] a,
                                input logic [XLEN-1:0] b, input logic [REG_ADDR_W-1:0] rd,
                                output logic [XLEN-1:0] data,
                                output logic [REG_ADDR_W-1:0] rd_out, output int latency);
        wait_idle();
        send_request(op, a, b, rd);
        @(negedge clk);
        req_valid = 1'b0;
        latency = 1; // Counted in falling edges after the accepting edge
        while (!result_valid && latency < TIMEOUT_CYCLES) begin
            @(negedge clk);
            latency++;
        end
        if (!result_valid) report_timeout("result_valid after an accepted request");
        data   = result_data;
        rd_out = result_rd;
    endtask

    task automatic check_division(input logic [DIV_OP_W-1:0] op, input logic [XLEN-1:0] a,
                                  input logic [XLEN-1:0] b, input logic [REG_ADDR_W-1:0] rd,
                                  input string what);
        logic [XLEN-1:0]       data;
        logic [REG_ADDR_W-1:0] rd_out;
        int                    latency;
        run_division(op, a, b, rd, data, rd_out, latency);
        check_value({what, " data"}, data, expected_result(op, a, b));
        check_value({what, " tag"}, XLEN'(rd_out), XLEN'(rd));
        check_value({what, " latency"}, XLEN'(latency), XLEN'(XLEN + 4));
    endtask

    task automatic expect_quiet(input string what);
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge clk);
            check_value({what, " result_valid"}, XLEN'(result_valid), '0);
            check_value({what, " busy"}, XLEN'(busy), '0);
        end
    endtask

    task automatic exercise_basic_ops();
        logic [XLEN-1:0]       a_list [6];
        logic [XLEN-1:0]       b_list [6];
        logic [XLEN-1:0]       data;
        logic [REG_ADDR_W-1:0] rd_out;
        int                    latency;
        a_list = '{-7, 7, -7, 7, 100, 32'h8000_0001};
        b_list = '{2, -2, -2, 2, 7, 3};
        for (int i = 0; i < 6; i++) begin
            for (int j = 0; j < 4; j++) begin
                check_division(DIV_OP_W'(j), a_list[i], b_list[i],
                               REG_ADDR_W'(i * 4 + j), "basic op");
            end
        end
        // Worked example of -7 by 2
        run_division(DIV_OP_DIV, 32'hFFFF_FFF9, 32'd2, 5'd1, data, rd_out, latency);
        check_value("DIV -7 by 2", data, 32'hFFFF_FFFD);
        run_division(DIV_OP_REM, 32'hFFFF_FFF9, 32'd2, 5'd2, data, rd_out, latency);
        check_value("REM -7 by 2", data, 32'hFFFF_FFFF);
        check_value("REM -7 by 2 tag", XLEN'(rd_out), 32'd2);
    endtask

    task automatic verify_corner_rules();
        logic [XLEN-1:0]       data;
        logic [REG_ADDR_W-1:0] rd_out;
        int                    latency;
        run_division(DIV_OP_DIV, 32'hFFFF_FFF0, 32'd0, 5'd4, data, rd_out, latency);
        check_value("DIV by zero", data, 32'hFFFF_FFFF);
        run_division(DIV_OP_DIVU, 32'd1234, 32'd0, 5'd5, data, rd_out, latency);
        check_value("DIVU by zero", data, 32'hFFFF_FFFF);
        run_division(DIV_OP_REM, 32'hFFFF_FFF0, 32'd0, 5'd6, data, rd_out, latency);
        check_value("REM by zero", data, 32'hFFFF_FFF0);
        run_division(DIV_OP_REMU, 32'd1234, 32'd0, 5'd7, data, rd_out, latency);
        check_value("REMU by zero", data, 32'd1234);
        run_division(DIV_OP_DIV, 32'h8000_0000, 32'hFFFF_FFFF, 5'd8, data, rd_out, latency);
        check_value("DIV overflow", data, 32'h8000_0000);
        run_division(DIV_OP_REM, 32'h8000_0000, 32'hFFFF_FFFF, 5'd9, data, rd_out, latency);
        check_value("REM overflow", data, 32'd0);
        check_division(DIV_OP_DIVU, 32'h8000_0000, 32'hFFFF_FFFF, 5'd10, "DIVU large");
        check_division(DIV_OP_REMU, 32'h8000_0000, 32'hFFFF_FFFF, 5'd11, "REMU large");
    endtask

    task automatic run_random_ops();
        logic [DIV_OP_W-1:0]   op;
        logic [XLEN-1:0]       a;
        logic [XLEN-1:0]       b;
        logic [REG_ADDR_W-1:0] rd;
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            op = DIV_OP_W'($urandom_range(3, 0));
            a  = $urandom;
            b  = $urandom;
            if ($urandom_range(7, 0) == 0) b = b >> 28; // Small divisors and now and then zero
            rd = REG_ADDR_W'($urandom_range(31, 0));
            check_division(op, a, b, rd, "random op");
        end
    endtask

    task automatic drop_request_while_busy();
        int latency;
        wait_idle();
        send_request(DIV_OP_DIVU, 32'd1000, 32'd7, 5'd3);
        @(negedge clk);
        latency = 1;
        send_request(DIV_OP_DIV, 32'd50, 32'd5, 5'd9); // Must be dropped
        repeat (4) begin
            check_value("busy during second request", XLEN'(busy), 32'd1);
            @(negedge clk);
            latency++;
        end
        req_valid = 1'b0;
        while (!result_valid && latency < TIMEOUT_CYCLES) begin
            @(negedge clk);
            latency++;
        end
        if (!result_valid) report_timeout("result_valid of the first request");
        check_value("busy test data", result_data, 32'd142);
        check_value("busy test tag", XLEN'(result_rd), 32'd3);
        check_value("busy test latency", XLEN'(latency), XLEN'(XLEN + 4));
        expect_quiet("after busy test");
    endtask

    task automatic block_start_on_flush();
        wait_idle();
        flush = 1'b1;
        send_request(DIV_OP_REM, 32'hFFFF_FF9C, 32'd7, 5'd12);
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            check_value("busy under flush", XLEN'(busy), '0);
        end
        req_valid = 1'b0;
        flush     = 1'b0;
        expect_quiet("after flushed request");
        check_division(DIV_OP_REM, 32'hFFFF_FF9C, 32'd7, 5'd12, "request after flush");
    endtask

    task automatic abandon_on_reset();
        wait_idle();
        send_request(DIV_OP_DIV, 32'd123456, 32'd789, 5'd20);
        @(negedge clk);
        req_valid = 1'b0;
        repeat (10) @(negedge clk);
        check_value("busy mid division", XLEN'(busy), 32'd1);
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        check_value("busy after reset", XLEN'(busy), '0);
        expect_quiet("after reset");
        check_division(DIV_OP_DIVU, 32'd123456, 32'd789, 5'd21, "request after reset");
    endtask

    initial begin
        void'($urandom(76));
        rst       = 1'b1;
        flush     = 1'b0;
        req_valid = 1'b0;
        req_op    = '0;
        req_rs1   = '0;
        req_rs2   = '0;
        req_rd    = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        exercise_basic_ops();
        verify_corner_rules();
        run_random_ops();
        drop_request_while_busy();
        block_start_on_flush();
        abandon_on_reset();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- div_unit_sva.sv
module div_unit_sva #(
    parameter int XLEN = div_pkg::XLEN_DEFAULT
) (
    input logic clk,
    input logic rst,
    input logic flush,
    input logic req_valid,
    input logic busy,
    input logic result_valid
);
    logic accept;

    assign accept = req_valid && !busy && !flush; // Same rule as the issue side

    a_single_pulse : assert property (@(posedge clk) disable iff (rst)
        result_valid |=> !result_valid)
        else $error("result_valid high for two cycles running");

    a_busy_on_accept : assert property (@(posedge clk) disable iff (rst)
        accept |=> busy)
        else $error("busy did not rise after an accepted request");

    // Busy only drops together with the result, except through reset
    a_busy_until_result : assert property (@(posedge clk) disable iff (rst)
        $fell(busy) && !$past(rst) |-> result_valid)
        else $error("busy fell without a result");

    a_reset_clears : assert property (@(posedge clk)
        rst |=> !result_valid)
        else $error("result_valid high right after reset");

    a_fixed_latency : assert property (@(posedge clk) disable iff (rst)
        accept |-> ##(XLEN + 4) result_valid)
        else $error("result_valid missing at the fixed latency");

endmodule

bind div_unit div_unit_sva #(.XLEN(XLEN)) sva0 (
    .clk(clk),
    .rst(rst),
    .flush(flush),
    .req_valid(req_valid),
    .busy(busy),
    .result_valid(result_valid)
);

//--- div_unit.sv
module div_unit #(
    parameter int XLEN = div_pkg::XLEN_DEFAULT
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           flush,
    input  logic                           req_valid,
    input  logic [div_pkg::DIV_OP_W-1:0]   req_op,
    input  logic [XLEN-1:0]                req_rs1,
    input  logic [XLEN-1:0]                req_rs2,
    input  logic [div_pkg::REG_ADDR_W-1:0] req_rd,
    output logic                           busy,         // Issue stage stalls on this
    output logic                           result_valid,
    output logic [div_pkg::REG_ADDR_W-1:0] result_rd,
    output logic [XLEN-1:0]                result_data
);
    logic                           start;
    logic                           done;
    logic [XLEN-1:0]                dividend_mag;
    logic [XLEN-1:0]                divisor_mag;
    logic [XLEN-1:0]                quotient;
    logic [XLEN-1:0]                remainder;
    logic                           neg_quot;
    logic                           neg_rem;
    logic                           sel_quot;
    logic [div_pkg::REG_ADDR_W-1:0] tag;

    // Input side, magnitudes and sign-fix flags
    div_issue #(.XLEN(XLEN)) issue0 (
        .clk, .rst, .flush,
        .req_valid, .req_op, .req_rs1, .req_rs2, .req_rd,
        .done,
        .busy, .start,
        .dividend_mag, .divisor_mag,
        .neg_quot, .neg_rem, .sel_quot, .tag
    );

    // Serial restoring divider
    div_core #(.XLEN(XLEN)) core0 (
        .clk, .rst, .start,
        .dividend_mag, .divisor_mag,
        .done, .quotient, .remainder
    );

    // Output side, result and tag to writeback
    div_writeback #(.XLEN(XLEN)) wb0 (
        .clk, .rst, .done,
        .quotient, .remainder,
        .neg_quot, .neg_rem, .sel_quot, .tag,
        .result_valid, .result_rd, .result_data
    );

endmodule

//--- div_writeback.sv
module div_writeback #(
    parameter int XLEN = div_pkg::XLEN_DEFAULT
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           done,
    input  logic [XLEN-1:0]                quotient,
    input  logic [XLEN-1:0]                remainder,
    input  logic                           neg_quot,
    input  logic                           neg_rem,
    input  logic                           sel_quot,
    input  logic [div_pkg::REG_ADDR_W-1:0] tag,
    output logic                           result_valid,
    output logic [div_pkg::REG_ADDR_W-1:0] result_rd,
    output logic [XLEN-1:0]                result_data
);
    logic [XLEN-1:0] quot_fixed;
    logic [XLEN-1:0] rem_fixed;

    // Signs restored from the flags recorded at issue
    assign quot_fixed = neg_quot ? -quotient : quotient;
    assign rem_fixed  = neg_rem ? -remainder : remainder;

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= done; // No back-pressure, pulse must be taken
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            result_rd   <= tag;
            result_data <= sel_quot ? quot_fixed : rem_fixed;
        end
    end

endmodule

//--- div_core.sv
module div_core #(
    parameter int XLEN = div_pkg::XLEN_DEFAULT
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  logic [XLEN-1:0] dividend_mag,
    input  logic [XLEN-1:0] divisor_mag,
    output logic            done,
    output logic [XLEN-1:0] quotient,
    output logic [XLEN-1:0] remainder
);
    localparam int CTR_W = $clog2(XLEN + 1);

    // FSM encoding
    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_BUSY   = 2'd1;
    localparam logic [1:0] ST_OUTPUT = 2'd2;

    logic [1:0]       state_q, state_d;
    logic [CTR_W-1:0] ctr_q, ctr_d;
    logic [XLEN-1:0]  divisor_q, divisor_d;
    logic [2*XLEN:0]  rq_q, rq_d;    // Partial remainder on top, quotient bits below
    logic [XLEN:0]    diff;          // MSB is the borrow

    assign diff = {1'b0, rq_q[2*XLEN-1:XLEN]} - {1'b0, divisor_q};

    always_ff @(posedge clk) begin
        if (rst) begin // Abandon any division in progress
            state_q <= ST_IDLE;
            ctr_q   <= '0;
        end else begin
            state_q <= state_d;
            ctr_q   <= ctr_d;
        end
    end

    always_ff @(posedge clk) begin
        divisor_q <= divisor_d;
        rq_q      <= rq_d;
    end

    always_comb begin
        state_d   = state_q;
        ctr_d     = ctr_q;
        divisor_d = divisor_q;
        rq_d      = rq_q;

        case (state_q)
            ST_IDLE: begin
                if (start) begin
                    // Extra leading zero bit makes XLEN+1 passes come out exact
                    rq_d      = {{(XLEN + 1){1'b0}}, dividend_mag};
                    divisor_d = divisor_mag;
                    ctr_d     = CTR_W'(XLEN);
                    state_d   = ST_BUSY;
                end
            end

            ST_BUSY: begin
                // Keep the difference unless it borrowed, quotient bit is the inverted borrow
                rq_d = {diff[XLEN] ? rq_q[2*XLEN-1:XLEN] : diff[XLEN-1:0],
                        rq_q[XLEN-1:0],
                        ~diff[XLEN]};
                ctr_d = ctr_q - 1'b1;
                if (ctr_q == '0) begin
                    state_d = ST_OUTPUT; // Last pass done
                end
            end

            ST_OUTPUT: begin
                state_d = ST_IDLE;
            end

            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    assign done = (state_q == ST_OUTPUT); // Single cycle, FSM leaves OUTPUT at once

    // Held until the next start reloads the register
    assign quotient  = rq_q[XLEN-1:0];
    assign remainder = rq_q[2*XLEN:XLEN+1];

endmodule

//--- div_issue.sv
module div_issue #(
    parameter int XLEN = div_pkg::XLEN_DEFAULT
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush,     // Branch taken in writeback
    input  logic                          req_valid,
    input  logic [div_pkg::DIV_OP_W-1:0]  req_op,
    input  logic [XLEN-1:0]               req_rs1,
    input  logic [XLEN-1:0]               req_rs2,
    input  logic [div_pkg::REG_ADDR_W-1:0] req_rd,
    input  logic                          done,      // From the core
    output logic                          busy,
    output logic                          start,
    output logic [XLEN-1:0]               dividend_mag,
    output logic [XLEN-1:0]               divisor_mag,
    output logic                          neg_quot,
    output logic                          neg_rem,
    output logic                          sel_quot,
    output logic [div_pkg::REG_ADDR_W-1:0] tag
);
    import div_pkg::*;

    logic accept;
    logic signed_op;
    logic rs1_neg;
    logic rs2_neg;

    // Only one division in flight, a request seen while busy is dropped
    assign accept    = req_valid && !busy && !flush;
    assign signed_op = (req_op != DIV_OP_DIVU) && (req_op != DIV_OP_REMU);
    assign rs1_neg   = signed_op && req_rs1[XLEN-1];
    assign rs2_neg   = signed_op && req_rs2[XLEN-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            start <= 1'b0;
        end else begin
            start <= accept; // Core kicks off the cycle after acceptance
            if (accept) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    // Operands and sign-fix flags held for the whole division
    always_ff @(posedge clk) begin
        if (accept) begin
            dividend_mag <= rs1_neg ? -req_rs1 : req_rs1;
            divisor_mag  <= rs2_neg ? -req_rs2 : req_rs2;

            // No quotient negation on divide by zero, result must stay all ones
            neg_quot <= (rs1_neg ^ rs2_neg) && (|req_rs2);
            neg_rem  <= rs1_neg; // Remainder takes the dividend sign
            sel_quot <= (req_op == DIV_OP_DIV) || (req_op == DIV_OP_DIVU);
            tag      <= req_rd;
        end
    end

endmodule

//--- div_pkg.sv
package div_pkg;

    // Operation code layout
    //   bit 0 set for the unsigned forms
    //   bit 1 set for the remainder forms
    localparam int DIV_OP_W = 2;

    localparam logic [DIV_OP_W-1:0] DIV_OP_DIV  = 2'd0; // Signed quotient
    localparam logic [DIV_OP_W-1:0] DIV_OP_DIVU = 2'd1; // Unsigned quotient
    localparam logic [DIV_OP_W-1:0] DIV_OP_REM  = 2'd2; // Signed remainder
    localparam logic [DIV_OP_W-1:0] DIV_OP_REMU = 2'd3; // Unsigned remainder

    // Destination register tag, x0..x31
    localparam int REG_ADDR_W = 5;

    // Operand width used when the top level is not overridden
    localparam int XLEN_DEFAULT = 32;

endpackage
